// ==== Bender.yml ====
package:
  name: tiny_cpu_2port

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tiny_cpu_pkg.sv
      - hdl/fetch_port.sv
      - hdl/lsu_port.sv
      - core/tiny_core.sv
      - hdl/tiny_cpu_2port.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/ahb_sram_model.sv
      - testbench/tiny_cpu_checker.sv
      - testbench/tb_tiny_cpu_2port.sv

// ==== build.f ====
+incdir+common
common/tiny_cpu_pkg.sv
hdl/fetch_port.sv
hdl/lsu_port.sv
core/tiny_core.sv
hdl/tiny_cpu_2port.sv
testbench/ahb_sram_model.sv
testbench/tiny_cpu_checker.sv
testbench/tb_tiny_cpu_2port.sv

// ==== common/tiny_cpu_config.svh ====
`ifndef TINY_CPU_CONFIG_SVH
`define TINY_CPU_CONFIG_SVH

// --------------------
// Bus widths

// Byte address on both AHB-Lite ports
`define TINY_W_ADDR 32

// One instruction or one data word per beat
`define TINY_W_DATA 32

// --------------------
// Boot

// First fetch address after reset, word aligned
`define TINY_RESET_VECTOR 32'h0000_0000

`endif

// ==== common/tiny_cpu_pkg.sv ====
`default_nettype none

`include "tiny_cpu_config.svh"

package tiny_cpu_pkg;

	// --------------------
	// AHB-Lite encodings
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [2:0] HSIZE_BYTE    = 3'b000;
	localparam logic [2:0] HSIZE_WORD    = 3'b010;
	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	// Data access, user mode
	localparam logic [3:0] HPROT_DATA    = 4'b0001;

	// --------------------
	// Core sequencing
	typedef enum logic [2:0] {
		FETCH      = 3'd0,
		FETCH_WAIT = 3'd1,
		EXECUTE    = 3'd2,
		MEM        = 3'd3,
		MEM_WAIT   = 3'd4,
		HALTED     = 3'd5,
		TRAPPED    = 3'd6
	} core_state_e;

	// Top byte of each instruction, all other codes illegal
	typedef enum logic [7:0] {
		OP_LDW  = 8'h01,
		OP_LDB  = 8'h02,
		OP_STW  = 8'h03,
		OP_STB  = 8'h04,
		OP_ADDI = 8'h05,
		OP_BNEZ = 8'h06,
		OP_JMP  = 8'h07,
		OP_HALT = 8'h08
	} opcode_e;

	typedef enum logic {
		SIZE_BYTE = 1'b0,
		SIZE_WORD = 1'b1
	} mem_size_e;

	// --------------------
	// Core to port requests
	typedef struct packed {
		logic                    req;
		logic [`TINY_W_ADDR-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic                    req;
		logic [`TINY_W_ADDR-1:0] addr;
		logic                    write;
		mem_size_e               size;
		logic [`TINY_W_DATA-1:0] wdata;
	} mem_req_t;

	// Shared by both ports
	typedef struct packed {
		logic                    aph_ready;
		logic                    dph_ready;
		// Valid only with dph_ready
		logic                    err;
		logic [`TINY_W_DATA-1:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== core/tiny_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module tiny_core (
	input  logic                     clk,
	input  logic                     rst_n,
	output tiny_cpu_pkg::fetch_req_t fetch_req_o,
	input  tiny_cpu_pkg::bus_rsp_t   fetch_rsp_i,
	output tiny_cpu_pkg::mem_req_t   mem_req_o,
	input  tiny_cpu_pkg::bus_rsp_t   mem_rsp_i,
	output logic [`TINY_W_DATA-1:0]  acc_o,
	output logic                     halted_o,
	output logic                     trap_o
);

	localparam logic [`TINY_W_ADDR-1:0] PC_STEP = 4;

	tiny_cpu_pkg::core_state_e state_q;
	tiny_cpu_pkg::opcode_e     opcode;

	logic [`TINY_W_ADDR-1:0] pc_q;
	logic [`TINY_W_ADDR-1:0] pc_inc;
	logic [`TINY_W_DATA-1:0] acc_q;
	logic [`TINY_W_DATA-1:0] instr_q;
	logic [23:0]             operand;
	logic [`TINY_W_DATA-1:0] imm_sext;
	logic [`TINY_W_ADDR-1:0] operand_zext;
	logic                    is_store;
	logic                    is_byte;

	// --------------------
	// Decode

	// Opcode in the top byte, 24-bit operand below
	assign opcode  = tiny_cpu_pkg::opcode_e'(instr_q[31:24]);
	assign operand = instr_q[23:0];

	// Signed immediate for ADDI
	assign imm_sext     = {{(`TINY_W_DATA-24){operand[23]}}, operand};
	// Addresses and branch targets, unsigned
	assign operand_zext = {{(`TINY_W_ADDR-24){1'b0}}, operand};
	assign pc_inc       = pc_q + PC_STEP;

	assign is_store = (opcode == tiny_cpu_pkg::OP_STW) || (opcode == tiny_cpu_pkg::OP_STB);
	assign is_byte  = (opcode == tiny_cpu_pkg::OP_LDB) || (opcode == tiny_cpu_pkg::OP_STB);

	// --------------------
	// Bus requests

	// Held steady by the state until accepted
	always_comb begin
		fetch_req_o.req  = (state_q == tiny_cpu_pkg::FETCH);
		fetch_req_o.addr = pc_q;

		mem_req_o.req   = (state_q == tiny_cpu_pkg::MEM);
		mem_req_o.addr  = operand_zext;
		mem_req_o.write = is_store;
		mem_req_o.size  = is_byte ? tiny_cpu_pkg::SIZE_BYTE : tiny_cpu_pkg::SIZE_WORD;
		// Stores always write the accumulator
		mem_req_o.wdata = acc_q;
	end

	// --------------------
	// Sequencing and execute

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= tiny_cpu_pkg::FETCH;
			pc_q    <= `TINY_RESET_VECTOR;
			acc_q   <= '0;
		end else begin
			case (state_q)
				tiny_cpu_pkg::FETCH: begin
					if (fetch_rsp_i.aph_ready) begin
						state_q <= tiny_cpu_pkg::FETCH_WAIT;
					end
				end
				tiny_cpu_pkg::FETCH_WAIT: begin
					// Bus fault or bad PC
					if (fetch_rsp_i.dph_ready) begin
						state_q <= fetch_rsp_i.err ? tiny_cpu_pkg::TRAPPED
							: tiny_cpu_pkg::EXECUTE;
					end
				end
				tiny_cpu_pkg::EXECUTE: begin
					case (opcode)
						tiny_cpu_pkg::OP_LDW,
						tiny_cpu_pkg::OP_LDB,
						tiny_cpu_pkg::OP_STW,
						tiny_cpu_pkg::OP_STB: begin
							state_q <= tiny_cpu_pkg::MEM;
						end
						tiny_cpu_pkg::OP_ADDI: begin
							acc_q   <= acc_q + imm_sext;
							pc_q    <= pc_inc;
							state_q <= tiny_cpu_pkg::FETCH;
						end
						tiny_cpu_pkg::OP_BNEZ: begin
							// Taken on any nonzero accumulator
							pc_q    <= (acc_q != '0) ? operand_zext : pc_inc;
							state_q <= tiny_cpu_pkg::FETCH;
						end
						tiny_cpu_pkg::OP_JMP: begin
							pc_q    <= operand_zext;
							state_q <= tiny_cpu_pkg::FETCH;
						end
						tiny_cpu_pkg::OP_HALT: begin
							state_q <= tiny_cpu_pkg::HALTED;
						end
						// Unknown opcode
						default: begin
							state_q <= tiny_cpu_pkg::TRAPPED;
						end
					endcase
				end
				tiny_cpu_pkg::MEM: begin
					if (mem_rsp_i.aph_ready) begin
						state_q <= tiny_cpu_pkg::MEM_WAIT;
					end
				end
				tiny_cpu_pkg::MEM_WAIT: begin
					if (mem_rsp_i.dph_ready) begin
						if (mem_rsp_i.err) begin
							state_q <= tiny_cpu_pkg::TRAPPED;
						end else begin
							// Loads replace the accumulator
							if (!is_store) begin
								acc_q <= mem_rsp_i.rdata;
							end
							pc_q    <= pc_inc;
							state_q <= tiny_cpu_pkg::FETCH;
						end
					end
				end
				// HALTED and TRAPPED hold until reset
				default: begin
					state_q <= state_q;
				end
			endcase
		end
	end

	// Instruction latch at end of fetch
	always_ff @(posedge clk) begin
		if (state_q == tiny_cpu_pkg::FETCH_WAIT && fetch_rsp_i.dph_ready) begin
			instr_q <= fetch_rsp_i.rdata;
		end
	end

	// --------------------
	// Status

	assign acc_o    = acc_q;
	assign halted_o = (state_q == tiny_cpu_pkg::HALTED);
	assign trap_o   = (state_q == tiny_cpu_pkg::TRAPPED);

endmodule

`default_nettype wire

// ==== hdl/fetch_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module fetch_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  tiny_cpu_pkg::fetch_req_t req_i,
	output tiny_cpu_pkg::bus_rsp_t   rsp_o,
	output logic [`TINY_W_ADDR-1:0]  haddr_o,
	output logic [1:0]               htrans_o,
	output logic [2:0]               hsize_o,
	output logic [2:0]               hburst_o,
	output logic [3:0]               hprot_o,
	input  logic                     hready_i,
	input  logic                     hresp_i,
	input  logic [`TINY_W_DATA-1:0]  hrdata_i
);

	// --------------------
	// Address phase

	logic misaligned;
	logic bus_req;
	logic dphase_q;
	logic local_err_q;

	// Word fetch only, so any low address bit set is bad
	assign misaligned = req_i.req && (req_i.addr[1:0] != 2'b00);
	// Bad fetches never reach the bus
	assign bus_req    = req_i.req && !misaligned;

	assign haddr_o  = req_i.addr;
	assign htrans_o = bus_req ? tiny_cpu_pkg::HTRANS_NONSEQ : tiny_cpu_pkg::HTRANS_IDLE;
	// Fixed attributes of a read-only instruction master
	assign hsize_o  = tiny_cpu_pkg::HSIZE_WORD;
	assign hburst_o = tiny_cpu_pkg::HBURST_SINGLE;
	assign hprot_o  = tiny_cpu_pkg::HPROT_DATA;

	// --------------------
	// Data phase tracking

	// Advances only when the slave is ready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dphase_q <= 1'b0;
		end else if (hready_i) begin
			dphase_q <= bus_req;
		end
	end

	// One-cycle local error for a refused fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			local_err_q <= 1'b0;
		end else begin
			local_err_q <= misaligned;
		end
	end

	// Refused fetch accepted at once, bus fetch waits for hready
	always_comb begin
		rsp_o.aph_ready = misaligned || (bus_req && hready_i);
		rsp_o.dph_ready = local_err_q || (dphase_q && hready_i);
		rsp_o.err       = local_err_q || (dphase_q && hready_i && hresp_i);
		// Instruction word straight from the bus
		rsp_o.rdata     = hrdata_i;
	end

endmodule

`default_nettype wire

// ==== hdl/lsu_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module lsu_port (
	input  logic                    clk,
	input  logic                    rst_n,
	input  tiny_cpu_pkg::mem_req_t  req_i,
	output tiny_cpu_pkg::bus_rsp_t  rsp_o,
	output logic [`TINY_W_ADDR-1:0] haddr_o,
	output logic [1:0]              htrans_o,
	output logic                    hwrite_o,
	output logic [2:0]              hsize_o,
	output logic [2:0]              hburst_o,
	output logic [3:0]              hprot_o,
	output logic [`TINY_W_DATA-1:0] hwdata_o,
	input  logic                    hready_i,
	input  logic                    hresp_i,
	input  logic [`TINY_W_DATA-1:0] hrdata_i
);

	logic                    is_byte;
	logic                    misaligned;
	logic                    bus_req;
	logic                    aph_done;
	logic                    dphase_q;
	logic                    local_err_q;
	logic [`TINY_W_DATA-1:0] wdata_q;
	logic [1:0]              lane_q;
	logic                    byte_q;
	logic [7:0]              rd_byte;

	// --------------------
	// Address phase

	assign is_byte    = (req_i.size == tiny_cpu_pkg::SIZE_BYTE);
	// Bytes may sit anywhere, words need a clean address
	assign misaligned = req_i.req && !is_byte && (req_i.addr[1:0] != 2'b00);
	assign bus_req    = req_i.req && !misaligned;
	assign aph_done   = bus_req && hready_i;

	assign haddr_o  = req_i.addr;
	assign htrans_o = bus_req ? tiny_cpu_pkg::HTRANS_NONSEQ : tiny_cpu_pkg::HTRANS_IDLE;
	assign hwrite_o = req_i.write;
	assign hsize_o  = is_byte ? tiny_cpu_pkg::HSIZE_BYTE : tiny_cpu_pkg::HSIZE_WORD;
	assign hburst_o = tiny_cpu_pkg::HBURST_SINGLE;
	assign hprot_o  = tiny_cpu_pkg::HPROT_DATA;

	// --------------------
	// Data phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dphase_q    <= 1'b0;
			local_err_q <= 1'b0;
		end else begin
			// Held while the slave stalls
			if (hready_i) begin
				dphase_q <= bus_req;
			end
			local_err_q <= misaligned;
		end
	end

	// Captured at accept, used one beat later
	always_ff @(posedge clk) begin
		if (aph_done) begin
			// Byte store lands on every lane, slave picks by address
			wdata_q <= is_byte ? {(`TINY_W_DATA/8){req_i.wdata[7:0]}} : req_i.wdata;
			lane_q  <= req_i.addr[1:0];
			byte_q  <= is_byte;
		end
	end

	assign hwdata_o = wdata_q;

	// Little-endian lane select
	assign rd_byte = hrdata_i[8*lane_q +: 8];

	always_comb begin
		rsp_o.aph_ready = misaligned || aph_done;
		rsp_o.dph_ready = local_err_q || (dphase_q && hready_i);
		rsp_o.err       = local_err_q || (dphase_q && hready_i && hresp_i);
		// Zero-extended byte or whole word
		if (byte_q) begin
			rsp_o.rdata = {{(`TINY_W_DATA-8){1'b0}}, rd_byte};
		end else begin
			rsp_o.rdata = hrdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tiny_cpu_2port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module tiny_cpu_2port (
	input  logic                    clk,
	input  logic                    rst_n,

	// Instruction fetch master
	output logic [`TINY_W_ADDR-1:0] i_haddr_o,
	output logic [1:0]              i_htrans_o,
	output logic [2:0]              i_hsize_o,
	output logic [2:0]              i_hburst_o,
	output logic [3:0]              i_hprot_o,
	input  logic                    i_hready_i,
	input  logic                    i_hresp_i,
	input  logic [`TINY_W_DATA-1:0] i_hrdata_i,

	// Load/store master
	output logic [`TINY_W_ADDR-1:0] d_haddr_o,
	output logic [1:0]              d_htrans_o,
	output logic                    d_hwrite_o,
	output logic [2:0]              d_hsize_o,
	output logic [2:0]              d_hburst_o,
	output logic [3:0]              d_hprot_o,
	output logic [`TINY_W_DATA-1:0] d_hwdata_o,
	input  logic                    d_hready_i,
	input  logic                    d_hresp_i,
	input  logic [`TINY_W_DATA-1:0] d_hrdata_i,

	// Status
	output logic [`TINY_W_DATA-1:0] acc_o,
	output logic                    halted_o,
	output logic                    trap_o
);

	tiny_cpu_pkg::fetch_req_t fetch_req;
	tiny_cpu_pkg::bus_rsp_t   fetch_rsp;
	tiny_cpu_pkg::mem_req_t   mem_req;
	tiny_cpu_pkg::bus_rsp_t   mem_rsp;

	// --------------------
	// Core

	tiny_core tiny_core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req_o (fetch_req),
		.fetch_rsp_i (fetch_rsp),
		.mem_req_o   (mem_req),
		.mem_rsp_i   (mem_rsp),
		.acc_o       (acc_o),
		.halted_o    (halted_o),
		.trap_o      (trap_o)
	);

	// --------------------
	// Fetch side
	fetch_port fetch_port_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_i    (fetch_req),
		.rsp_o    (fetch_rsp),
		.haddr_o  (i_haddr_o),
		.htrans_o (i_htrans_o),
		.hsize_o  (i_hsize_o),
		.hburst_o (i_hburst_o),
		.hprot_o  (i_hprot_o),
		.hready_i (i_hready_i),
		.hresp_i  (i_hresp_i),
		.hrdata_i (i_hrdata_i)
	);

	// --------------------
	// Load/store side
	lsu_port lsu_port_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_i    (mem_req),
		.rsp_o    (mem_rsp),
		.haddr_o  (d_haddr_o),
		.htrans_o (d_htrans_o),
		.hwrite_o (d_hwrite_o),
		.hsize_o  (d_hsize_o),
		.hburst_o (d_hburst_o),
		.hprot_o  (d_hprot_o),
		.hwdata_o (d_hwdata_o),
		.hready_i (d_hready_i),
		.hresp_i  (d_hresp_i),
		.hrdata_i (d_hrdata_i)
	);

endmodule

`default_nettype wire

// ==== testbench/ahb_sram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module ahb_sram_model #(
	parameter int DEPTH    = 256,
	parameter int MAX_WAIT = 3
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`TINY_W_ADDR-1:0] haddr_i,
	input  logic [1:0]              htrans_i,
	input  logic                    hwrite_i,
	input  logic [2:0]              hsize_i,
	input  logic [`TINY_W_DATA-1:0] hwdata_i,
	output logic                    hready_o,
	output logic                    hresp_o,
	output logic [`TINY_W_DATA-1:0] hrdata_o,
	// Error injection on one exact address
	input  logic                    err_en_i,
	input  logic [`TINY_W_ADDR-1:0] err_addr_i,
	output logic [31:0]             xfer_count_o
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [`TINY_W_DATA-1:0] mem [DEPTH];

	logic                    dph_q;
	logic                    write_q;
	logic                    err_q;
	logic [2:0]              size_q;
	logic [`TINY_W_ADDR-1:0] addr_q;
	logic [3:0]              wait_q;

	// Whole word, the master picks the lane
	assign hrdata_o = dph_q ? mem[addr_q[IDX_W+1:2]] : '0;

	// --------------------
	// Slave sequencing
	always @(posedge clk or negedge rst_n) begin : slave_seq
		logic [3:0] wait_n;
		logic       fail;
		if (!rst_n) begin
			dph_q        <= 1'b0;
			write_q      <= 1'b0;
			err_q        <= 1'b0;
			size_q       <= '0;
			addr_q       <= '0;
			wait_q       <= '0;
			hready_o     <= 1'b1;
			hresp_o      <= 1'b0;
			xfer_count_o <= '0;
		end else if (hready_o) begin
			// Previous data phase ends on this edge, errored writes dropped
			if (dph_q && write_q && !hresp_o) begin
				if (size_q == tiny_cpu_pkg::HSIZE_BYTE) begin
					mem[addr_q[IDX_W+1:2]][8*addr_q[1:0] +: 8] <= hwdata_i[8*addr_q[1:0] +: 8];
				end else begin
					mem[addr_q[IDX_W+1:2]] <= hwdata_i;
				end
			end
			hresp_o <= 1'b0;
			dph_q   <= htrans_i[1];
			// New address phase
			if (htrans_i[1]) begin
				wait_n = 4'($urandom % (MAX_WAIT + 1));
				fail   = err_en_i && (haddr_i == err_addr_i);
				addr_q       <= haddr_i;
				write_q      <= hwrite_i;
				size_q       <= hsize_i;
				err_q        <= fail;
				wait_q       <= wait_n;
				xfer_count_o <= xfer_count_o + 1;
				if (wait_n != 0 || fail) begin
					hready_o <= 1'b0;
				end
			end
		end else if (wait_q > 1) begin
			wait_q <= wait_q - 1;
		end else if (err_q && !hresp_o) begin
			// First beat of the two-cycle ERROR response
			wait_q  <= '0;
			hresp_o <= 1'b1;
		end else begin
			wait_q   <= '0;
			hready_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_tiny_cpu_2port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module tb_tiny_cpu_2port;

	localparam int DEPTH        = 256;
	localparam int IDX_W        = $clog2(DEPTH);
	localparam int STOP_TIMEOUT = 2000;

	logic clk;
	logic rst_n;

	// Fetch bus
	logic [`TINY_W_ADDR-1:0] i_haddr;
	logic [1:0]              i_htrans;
	logic [2:0]              i_hsize;
	logic [2:0]              i_hburst;
	logic [3:0]              i_hprot;
	logic                    i_hready;
	logic                    i_hresp;
	logic [`TINY_W_DATA-1:0] i_hrdata;

	// Data bus
	logic [`TINY_W_ADDR-1:0] d_haddr;
	logic [1:0]              d_htrans;
	logic                    d_hwrite;
	logic [2:0]              d_hsize;
	logic [2:0]              d_hburst;
	logic [3:0]              d_hprot;
	logic [`TINY_W_DATA-1:0] d_hwdata;
	logic                    d_hready;
	logic                    d_hresp;
	logic [`TINY_W_DATA-1:0] d_hrdata;
	logic [31:0]             d_xfer_count;

	logic [`TINY_W_DATA-1:0] acc;
	logic                    halted;
	logic                    trap;

	logic                    err_en;
	logic [`TINY_W_ADDR-1:0] err_addr;

	// Reference state built alongside each program
	logic [`TINY_W_DATA-1:0] exp_dmem [DEPTH];
	logic [`TINY_W_DATA-1:0] model_acc;
	int                      pc_idx;
	int                      errors;
	int                      checks;

	always #2 clk = ~clk;

	// --------------------
	// DUT and bus slaves
	tiny_cpu_2port tiny_cpu_2port_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_haddr_o  (i_haddr),
		.i_htrans_o (i_htrans),
		.i_hsize_o  (i_hsize),
		.i_hburst_o (i_hburst),
		.i_hprot_o  (i_hprot),
		.i_hready_i (i_hready),
		.i_hresp_i  (i_hresp),
		.i_hrdata_i (i_hrdata),
		.d_haddr_o  (d_haddr),
		.d_htrans_o (d_htrans),
		.d_hwrite_o (d_hwrite),
		.d_hsize_o  (d_hsize),
		.d_hburst_o (d_hburst),
		.d_hprot_o  (d_hprot),
		.d_hwdata_o (d_hwdata),
		.d_hready_i (d_hready),
		.d_hresp_i  (d_hresp),
		.d_hrdata_i (d_hrdata),
		.acc_o      (acc),
		.halted_o   (halted),
		.trap_o     (trap)
	);

	ahb_sram_model #(.DEPTH(DEPTH)) imem_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.haddr_i      (i_haddr),
		.htrans_i     (i_htrans),
		.hwrite_i     (1'b0),
		.hsize_i      (i_hsize),
		.hwdata_i     ('0),
		.hready_o     (i_hready),
		.hresp_o      (i_hresp),
		.hrdata_o     (i_hrdata),
		.err_en_i     (1'b0),
		.err_addr_i   ('0),
		.xfer_count_o ()
	);

	ahb_sram_model #(.DEPTH(DEPTH)) dmem_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.haddr_i      (d_haddr),
		.htrans_i     (d_htrans),
		.hwrite_i     (d_hwrite),
		.hsize_i      (d_hsize),
		.hwdata_i     (d_hwdata),
		.hready_o     (d_hready),
		.hresp_o      (d_hresp),
		.hrdata_o     (d_hrdata),
		.err_en_i     (err_en),
		.err_addr_i   (err_addr),
		.xfer_count_o (d_xfer_count)
	);

	// --------------------
	// Helpers

	// Mixes every address bit into the word
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'hc8e3_a59b;
	endfunction

	function automatic logic [31:0] sext24(input logic [23:0] v);
		return {{8{v[23]}}, v};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_flags(input logic exp_halted, input logic exp_trap);
		check_value("halted_o", 32'(halted), 32'(exp_halted));
		check_value("trap_o", 32'(trap), 32'(exp_trap));
	endtask

	// Word size on fetch, single burst, data access in user mode
	task automatic check_fixed_attrs();
		if (i_htrans == 2'b10) begin
			check_value("i_hsize_o", 32'(i_hsize), 32'h0000_0002);
			check_value("i_hburst_o", 32'(i_hburst), 32'h0000_0000);
			check_value("i_hprot_o", 32'(i_hprot), 32'h0000_0001);
		end
		if (d_htrans == 2'b10) begin
			check_value("d_hburst_o", 32'(d_hburst), 32'h0000_0000);
			check_value("d_hprot_o", 32'(d_hprot), 32'h0000_0001);
		end
	endtask

	task automatic check_dmem();
		int k;
		for (k = 0; k < DEPTH; k++) begin
			check_value($sformatf("dmem[%03h]", k * 4), dmem_i.mem[k], exp_dmem[k]);
		end
	endtask

	// Reset held while both memories are refilled
	task automatic begin_program(input string name);
		int k;
		@(negedge clk);
		rst_n     = 1'b0;
		err_en    = 1'b0;
		err_addr  = '0;
		pc_idx    = 0;
		model_acc = '0;
		for (k = 0; k < DEPTH; k++) begin
			imem_i.mem[k] = fill_word(k * 4);
			dmem_i.mem[k] = fill_word(k * 4);
			exp_dmem[k]   = fill_word(k * 4);
		end
		$display("Test: %s", name);
	endtask

	task automatic emit(input logic [7:0] op, input logic [23:0] operand);
		imem_i.mem[pc_idx] = {op, operand};
		pc_idx++;
	endtask

	task automatic addi(input logic [23:0] imm);
		emit(tiny_cpu_pkg::OP_ADDI, imm);
		model_acc = model_acc + sext24(imm);
	endtask

	task automatic preset_word(input logic [31:0] addr, input logic [31:0] value);
		dmem_i.mem[addr[IDX_W+1:2]] = value;
		exp_dmem[addr[IDX_W+1:2]]   = value;
	endtask

	task automatic store_word(input logic [23:0] addr);
		emit(tiny_cpu_pkg::OP_STW, addr);
		exp_dmem[addr[IDX_W+1:2]] = model_acc;
	endtask

	// Only the addressed lane changes
	task automatic store_byte(input logic [23:0] addr);
		emit(tiny_cpu_pkg::OP_STB, addr);
		exp_dmem[addr[IDX_W+1:2]][8*addr[1:0] +: 8] = model_acc[7:0];
	endtask

	task automatic load_word(input logic [23:0] addr);
		emit(tiny_cpu_pkg::OP_LDW, addr);
		model_acc = exp_dmem[addr[IDX_W+1:2]];
	endtask

	// Little-endian byte, zero-extended
	task automatic load_byte(input logic [23:0] addr);
		emit(tiny_cpu_pkg::OP_LDB, addr);
		model_acc = {24'h0, exp_dmem[addr[IDX_W+1:2]][8*addr[1:0] +: 8]};
	endtask

	task automatic run_to_stop();
		int n;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		n = 0;
		while (!(halted || trap) && n < STOP_TIMEOUT) begin
			@(negedge clk);
			n++;
			check_fixed_attrs();
		end
		if (!(halted || trap)) begin
			errors++;
			$display("Core neither halted nor trapped within %0d cycles", STOP_TIMEOUT);
		end
		// Flags are levels, so they must still hold a little later
		repeat (4) @(negedge clk);
	endtask

	// --------------------
	// Directed tests

	task automatic test_arith();
		begin_program("arithmetic and halt");
		addi(24'd1000);
		addi(24'hFFF830);
		addi(24'h7FFFFF);
		addi(24'h800000);
		addi(24'hFFFFFF);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_value("acc_o", acc, model_acc);
		check_flags(1'b1, 1'b0);
	endtask

	task automatic test_word();
		begin_program("word load and store");
		preset_word(32'h100, 32'h1234_5678);
		load_word(24'h000100);
		addi(24'hFFFF10);
		store_word(24'h000180);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_value("acc_o", acc, model_acc);
		check_flags(1'b1, 1'b0);
		check_dmem();
	endtask

	task automatic test_bytes();
		begin_program("byte access");
		addi(24'h0000C3);
		store_byte(24'h000200);
		addi(24'h000021);
		store_byte(24'h000205);
		addi(24'h0000F0);
		store_byte(24'h00020A);
		addi(24'hFFFF7B);
		store_byte(24'h00020F);
		// Untouched lane with its top bit set
		load_byte(24'h00020D);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_value("acc_o", acc, model_acc);
		check_flags(1'b1, 1'b0);
		check_dmem();
	endtask

	task automatic test_control();
		begin_program("countdown loop and jump");
		emit(tiny_cpu_pkg::OP_ADDI, 24'd5);
		emit(tiny_cpu_pkg::OP_ADDI, 24'hFFFFFF);
		emit(tiny_cpu_pkg::OP_BNEZ, 24'h000004);
		emit(tiny_cpu_pkg::OP_JMP, 24'h000020);
		// Reached only if the jump fails
		emit(tiny_cpu_pkg::OP_ADDI, 24'h000100);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		model_acc = sext24(24'd5);
		do begin
			model_acc = model_acc + sext24(24'hFFFFFF);
		end while (model_acc != 0);
		pc_idx = 8;
		addi(24'h00002A);
		store_word(24'h000300);
		addi(24'h000001);
		store_word(24'h000304);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_value("acc_o", acc, model_acc);
		check_flags(1'b1, 1'b0);
		check_dmem();
	endtask

	task automatic test_errors();
		begin_program("misaligned word load");
		addi(24'h000007);
		emit(tiny_cpu_pkg::OP_LDW, 24'h000102);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_flags(1'b0, 1'b1);
		check_value("acc_o", acc, model_acc);
		check_value("d_xfer_count", d_xfer_count, 32'd0);

		begin_program("illegal opcode");
		addi(24'h000001);
		emit(8'hEE, 24'h0);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_flags(1'b0, 1'b1);
		check_value("acc_o", acc, model_acc);

		begin_program("bus error on load");
		err_en   = 1'b1;
		err_addr = 32'h140;
		addi(24'h000003);
		emit(tiny_cpu_pkg::OP_LDW, 24'h000140);
		emit(tiny_cpu_pkg::OP_HALT, 24'h0);
		run_to_stop();
		check_flags(1'b0, 1'b1);
		check_value("acc_o", acc, model_acc);
		check_value("d_xfer_count", d_xfer_count, 32'd1);
		check_dmem();
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		err_en   = 1'b0;
		err_addr = '0;
		errors   = 0;
		checks   = 0;
		void'($urandom(32'hdb13_6791));
		test_arith();
		test_word();
		test_bytes();
		test_control();
		test_errors();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tiny_cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tiny_cpu_config.svh"

module tiny_cpu_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`TINY_W_ADDR-1:0] i_haddr_i,
	input logic [1:0]              i_htrans_i,
	input logic                    i_hready_i,
	input logic [`TINY_W_ADDR-1:0] d_haddr_i,
	input logic [1:0]              d_htrans_i,
	input logic [2:0]              d_hsize_i,
	input logic                    d_hready_i,
	input logic                    halted_i,
	input logic                    trap_i
);

	// --------------------
	// Address phase held through wait states
	fetch_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(i_htrans_i == tiny_cpu_pkg::HTRANS_NONSEQ && !i_hready_i)
		|=> ($stable(i_haddr_i) && $stable(i_htrans_i)))
		else $error("fetch address phase changed while hready was low");

	data_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(d_htrans_i == tiny_cpu_pkg::HTRANS_NONSEQ && !d_hready_i)
		|=> ($stable(d_haddr_i) && $stable(d_htrans_i)))
		else $error("data address phase changed while hready was low");

	// --------------------
	// Misaligned words never reach the data bus
	data_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(d_htrans_i == tiny_cpu_pkg::HTRANS_NONSEQ && d_hsize_i == tiny_cpu_pkg::HSIZE_WORD)
		|-> (d_haddr_i[1:0] == 2'b00))
		else $error("misaligned word access reached the data bus");

	// Halt and trap are end states held until reset
	stop_levels_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(halted_i || trap_i) |=> ($stable(halted_i) && $stable(trap_i)))
		else $error("halted_o or trap_o changed before reset");

endmodule

bind tiny_cpu_2port tiny_cpu_checker tiny_cpu_checker_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_haddr_i  (i_haddr_o),
	.i_htrans_i (i_htrans_o),
	.i_hready_i (i_hready_i),
	.d_haddr_i  (d_haddr_o),
	.d_htrans_i (d_htrans_o),
	.d_hsize_i  (d_hsize_o),
	.d_hready_i (d_hready_i),
	.halted_i   (halted_o),
	.trap_i     (trap_o)
);

`default_nettype wire
